/* Bender.yml */
package:
  name: ddr_wr_rd

sources:
  - verilog/ddr_wr_pkg.sv
  - verilog/sample_gen.sv
  - verilog/burst_fifo.sv
  - verilog/axi_burst_master.sv
  - verilog/ddr_wr_rd_top.sv
  - target: simulation
    files:
      - testbench/tb_axi_mem.sv
      - testbench/tb_ddr_wr_rd.sv

/* filelist.f */
verilog/ddr_wr_pkg.sv
verilog/sample_gen.sv
verilog/burst_fifo.sv
verilog/axi_burst_master.sv
verilog/ddr_wr_rd_top.sv
testbench/tb_axi_mem.sv
testbench/tb_ddr_wr_rd.sv

/* testbench/tb_axi_mem.sv */
`timescale 1ns/1ps

module tb_axi_mem #(
  parameter logic [31:0] SEED = 32'h085f1b42  // stall pattern seed
) (
  input  logic                c0_ddr4_ui_clk,
  input  logic                rst_n,
  input  ddr_wr_pkg::axi_aw_t aw,
  input  logic                awvalid,
  output logic                awready,
  input  ddr_wr_pkg::axi_w_t  w,
  input  logic                wvalid,
  output logic                wready,
  output logic                bvalid,
  input  logic                bready,
  input  ddr_wr_pkg::axi_ar_t ar,
  input  logic                arvalid,
  output logic                arready,
  output ddr_wr_pkg::axi_r_t  r,
  output logic                rvalid,
  input  logic                rready
);

  import ddr_wr_pkg::*;

  beat_t       store [1024];  // one entry per 16-byte line
  logic [31:0] lfsr_q;
  addr_t       wr_q [$];      // accepted aw addresses
  axi_ar_t     rd_q [$];      // accepted ar bursts
  int          w_beat;        // beat inside current write burst
  int          r_beat;        // beat inside current read burst
  int          b_pend;        // bursts waiting for a response
  logic        aw_hs, w_hs, b_hs, ar_hs, r_hs;
  logic        stall;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32,22,2,1
  endfunction

  task automatic draw_bit(output logic b);
    lfsr_q = lfsr_step(lfsr_q);  // one step per bit taken
    b = lfsr_q[0];
  endtask

  function automatic int line_of(input addr_t a);
    return int'(a[13:4]);  // 16-byte beats, 16 KiB window
  endfunction

  initial begin
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    arready = 1'b0;
    rvalid  = 1'b0;
    r       = '0;
    lfsr_q  = SEED;
    w_beat  = 0;
    r_beat  = 0;
    b_pend  = 0;
    forever begin
      @(negedge c0_ddr4_ui_clk);  // inputs settled until next edge
      aw_hs = rst_n && awvalid && awready;
      w_hs  = rst_n && wvalid && wready;
      b_hs  = rst_n && bvalid && bready;
      ar_hs = rst_n && arvalid && arready;
      r_hs  = rst_n && rvalid && rready;
      if (aw_hs) wr_q.push_back(aw.addr);
      if (ar_hs) rd_q.push_back(ar);
      if (w_hs) begin
        store[line_of(wr_q[0] + addr_t'(w_beat * 16))] = w.data;
        if (w.last) begin
          void'(wr_q.pop_front());
          w_beat = 0;
          b_pend++;  // response owed
        end else begin
          w_beat++;
        end
      end
      @(posedge c0_ddr4_ui_clk);
      #2;
      draw_bit(stall);
      awready = !stall;
      draw_bit(stall);
      wready = !stall;
      draw_bit(stall);
      arready = !stall;
      if (b_hs) begin
        bvalid = 1'b0;
        b_pend--;
      end
      if (!bvalid && b_pend != 0) begin
        draw_bit(stall);
        bvalid = !stall;  // random delay before the response
      end
      if (r_hs) begin
        rvalid = 1'b0;
        if (r.last) begin
          void'(rd_q.pop_front());
          r_beat = 0;
        end else begin
          r_beat++;
        end
      end
      if (!rvalid && rd_q.size() != 0) begin
        r.data = store[line_of(rd_q[0].addr + addr_t'(r_beat * 16))];
        r.last = (r_beat == int'(rd_q[0].len));
        rvalid = 1'b1;  // held until rready
      end
    end
  end

endmodule

/* testbench/tb_ddr_wr_rd.sv */
`timescale 1ns/1ps

module tb_ddr_wr_rd;

  import ddr_wr_pkg::*;

  localparam int unsigned BURST_LEN   = 4;
  localparam int unsigned FIFO_DEPTH  = 16;
  localparam addr_t       WR_BASE     = 30'h0000_1000;
  localparam int          BURST_BYTES = BURST_LEN * (DATA_W / 8);  // 64
  localparam logic [7:0]  LEN_FIELD   = 8'(BURST_LEN - 1);
  localparam int          WIN1        = 120;  // first wr_en window, cycles
  localparam int          WIN2        = 120;  // second window, with reads
  localparam int          READS       = 6;
  localparam int          EXP_BEATS   = (WIN1 + WIN2) / WORDS_PER_BEAT + READS * BURST_LEN;
  localparam int          TIMEOUT_CYC = 40 * EXP_BEATS + 500;

  logic    c0_ddr4_ui_clk;
  logic    rst_n;
  logic    wr_en;
  axi_aw_t aw;
  logic    awvalid, awready;
  axi_w_t  w;
  logic    wvalid, wready;
  logic    bvalid, bready;
  axi_ar_t ar;
  logic    arvalid, arready;
  axi_r_t  r;
  logic    rvalid, rready;
  addr_t   rd_req;
  logic    rd_req_valid, rd_req_ready;
  axi_r_t  rd_data;
  logic    rd_data_valid, rd_data_ready;

  int      aw_cnt, wr_beats, b_cnt, rd_beats, b_first, cycles;
  int      exp_rd [$];  // beat indices owed to the read port
  axi_ar_t exp_ar [$];
  axi_aw_t exp_aw;
  axi_ar_t exp_arv;
  axi_r_t  exp_r;

  ddr_wr_rd_top #(
    .BURST_LEN  (BURST_LEN),
    .FIFO_DEPTH (FIFO_DEPTH),
    .WR_BASE    (WR_BASE)
  ) dut (.*);

  tb_axi_mem #(.SEED(32'h085f1b42)) mem (
    .c0_ddr4_ui_clk, .rst_n, .aw, .awvalid, .awready, .w, .wvalid, .wready,
    .bvalid, .bready, .ar, .arvalid, .arready, .r, .rvalid, .rready
  );

  initial begin
    c0_ddr4_ui_clk = 1'b0;
    forever #20 c0_ddr4_ui_clk = ~c0_ddr4_ui_clk;  // 40 ns
  end

  ////////////////////////////////////////
  // reference and compare
  ////////////////////////////////////////
  function automatic beat_t ref_beat(input int unsigned k);
    beat_t b;
    for (int i = 0; i < WORDS_PER_BEAT; i++) begin
      b[i] = sample_t'(k * WORDS_PER_BEAT + i);  // sample 0 in low word
    end
    return b;
  endfunction

  task automatic fail_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_beat(input string name, input beat_t got, input beat_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_aw(input string name, input axi_aw_t got, input axi_aw_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_ar(input string name, input axi_ar_t got, input axi_ar_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_r(input string name, input axi_r_t got, input axi_r_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  // all handshakes judged on settled values before the next edge
  always @(negedge c0_ddr4_ui_clk) begin
    if (rst_n) begin
      if (awvalid && awready) begin
        exp_aw.addr = WR_BASE + addr_t'(aw_cnt * BURST_BYTES);
        exp_aw.len  = LEN_FIELD;
        check_aw("aw", aw, exp_aw);
        aw_cnt++;
      end
      if (wvalid && wready) begin
        check_beat("w.data", w.data, ref_beat(wr_beats));
        check_flag("w.last", w.last, (wr_beats % BURST_LEN) == BURST_LEN - 1);
        wr_beats++;  // running index, kept across windows
      end
      if (bvalid && bready) b_cnt++;
      if (rd_req_valid && rd_req_ready) begin
        exp_arv.addr = rd_req;
        exp_arv.len  = LEN_FIELD;
        exp_ar.push_back(exp_arv);
        for (int i = 0; i < BURST_LEN; i++) begin
          exp_rd.push_back(int'((rd_req - WR_BASE) / (DATA_W / 8)) + i);
        end
      end
      if (arvalid && arready) begin
        if (exp_ar.size() == 0) begin
          $display("read address issued without a user request");
          fail_run();
        end
        check_ar("ar", ar, exp_ar.pop_front());
      end
      if (rd_data_valid && rd_data_ready) begin
        if (exp_rd.size() == 0) begin
          $display("read data returned with no beat outstanding");
          fail_run();
        end
        exp_r.data = ref_beat(exp_rd[0]);
        exp_r.last = (exp_rd.size() == 1);
        void'(exp_rd.pop_front());
        check_r("rd_data", rd_data, exp_r);
        rd_beats++;
      end
    end
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////
  task automatic write_window(input int len);
    @(posedge c0_ddr4_ui_clk);
    #2 wr_en = 1'b1;
    repeat (len) @(posedge c0_ddr4_ui_clk);
    #2 wr_en = 1'b0;
  endtask

  // master idle long enough that no burst is left to start
  task automatic wait_write_idle();
    int quiet;
    quiet = 0;
    while (quiet < 8) begin
      @(negedge c0_ddr4_ui_clk);
      if (awvalid || wvalid || bready) quiet = 0;
      else quiet++;
    end
  endtask

  task automatic read_burst(input int n);
    @(posedge c0_ddr4_ui_clk);
    #2;
    rd_req       = WR_BASE + addr_t'(n * BURST_BYTES);
    rd_req_valid = 1'b1;
    do @(negedge c0_ddr4_ui_clk); while (!rd_req_ready);
    @(posedge c0_ddr4_ui_clk);
    #2 rd_req_valid = 1'b0;
    while (exp_rd.size() != 0) @(posedge c0_ddr4_ui_clk);  // burst returned
  endtask

  // user side holds off read data one cycle in three
  initial begin
    rd_data_ready = 1'b1;
    forever begin
      @(posedge c0_ddr4_ui_clk);
      #2 rd_data_ready = (cycles % 3) != 0;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYC) begin
      @(posedge c0_ddr4_ui_clk);
      cycles++;
    end
    $display("timeout: run still busy after %0d cycles", cycles);
    fail_run();
  end

  initial begin
    rst_n         = 1'b0;
    wr_en         = 1'b0;
    rd_req        = '0;
    rd_req_valid  = 1'b0;
    aw_cnt        = 0;
    wr_beats      = 0;
    b_cnt         = 0;
    rd_beats      = 0;
    repeat (2) @(posedge c0_ddr4_ui_clk);
    #2 rst_n = 1'b1;
    @(negedge c0_ddr4_ui_clk);
    check_flag("awvalid", awvalid, 1'b0);
    check_flag("wvalid", wvalid, 1'b0);
    check_flag("bready", bready, 1'b0);
    check_flag("arvalid", arvalid, 1'b0);
    check_flag("rready", rready, 1'b0);
    check_flag("rd_data_valid", rd_data_valid, 1'b0);
    check_flag("rd_req_ready", rd_req_ready, 1'b1);

    write_window(WIN1);  // writes alone
    wait_write_idle();
    b_first = b_cnt;
    if (b_first < 2) begin
      $display("too few bursts written in the first window: %0d", b_first);
      fail_run();
    end
    read_burst(0);
    read_burst(b_first - 1);

    fork  // reads against live writes
      write_window(WIN2);
      for (int i = 0; i < READS - 2; i++) begin
        read_burst((i * 3 + 1) % b_first);
      end
    join
    wait_write_idle();

    if (wr_beats == 0 || wr_beats % BURST_LEN != 0 || b_cnt * BURST_LEN != wr_beats ||
        aw_cnt != b_cnt || rd_beats != READS * BURST_LEN) begin
      $display("beat counts do not add up: %0d written in %0d bursts, %0d read",
               wr_beats, b_cnt, rd_beats);
      fail_run();
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

/* verilog/axi_burst_master.sv */
`timescale 1ns/1ps

module axi_burst_master #(
  parameter int unsigned        BURST_LEN = 4,   // beats per burst
  parameter ddr_wr_pkg::addr_t  WR_BASE   = '0   // first write address
) (
  input  logic                c0_ddr4_ui_clk,
  input  logic                rst_n,
  // write buffer side
  input  ddr_wr_pkg::beat_t   beat,
  input  logic                beat_valid,
  output logic                beat_ready,
  input  logic                burst_avail,
  // axi write channels
  output ddr_wr_pkg::axi_aw_t aw,
  output logic                awvalid,
  input  logic                awready,
  output ddr_wr_pkg::axi_w_t  w,
  output logic                wvalid,
  input  logic                wready,
  input  logic                bvalid,
  output logic                bready,
  // axi read channels
  output ddr_wr_pkg::axi_ar_t ar,
  output logic                arvalid,
  input  logic                arready,
  input  ddr_wr_pkg::axi_r_t  r,
  input  logic                rvalid,
  output logic                rready,
  // user read port
  input  ddr_wr_pkg::addr_t   rd_req,
  input  logic                rd_req_valid,
  output logic                rd_req_ready,
  output ddr_wr_pkg::axi_r_t  rd_data,
  output logic                rd_data_valid,
  input  logic                rd_data_ready
);

  import ddr_wr_pkg::*;

  localparam logic [7:0] LAST_IDX = 8'(BURST_LEN - 1);            // axi len field
  localparam addr_t      WR_STEP  = addr_t'(BURST_LEN * (DATA_W / 8)); // bytes per burst

  ////////////////////////////////////////
  // write side
  ////////////////////////////////////////
  wr_state_e  wr_state_q;
  wr_state_e  wr_state_d;
  addr_t      wr_addr_q;  // next burst address
  logic [7:0] wbeat_q;    // beat index inside burst
  logic       w_fire;
  logic       b_fire;

  assign awvalid   = (wr_state_q == WR_ADDR);
  assign aw.addr   = wr_addr_q;
  assign aw.len    = LAST_IDX;

  assign wvalid     = (wr_state_q == WR_DATA) && beat_valid;
  assign beat_ready = (wr_state_q == WR_DATA) && wready;  // pop on w handshake
  assign w.data     = beat;
  assign w.last     = (wbeat_q == LAST_IDX);
  assign w_fire     = wvalid && wready;

  assign bready = (wr_state_q == WR_RESP);
  assign b_fire = bvalid && bready;

  always_comb begin
    wr_state_d = wr_state_q;
    case (wr_state_q)
      WR_IDLE: if (burst_avail) wr_state_d = WR_ADDR;  // one burst per threshold
      WR_ADDR: if (awready) wr_state_d = WR_DATA;
      WR_DATA: if (w_fire && w.last) wr_state_d = WR_RESP;
      WR_RESP: if (bvalid) wr_state_d = WR_IDLE;
      default: wr_state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge c0_ddr4_ui_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_state_q <= WR_IDLE;
      wr_addr_q  <= WR_BASE;
      wbeat_q    <= '0;
    end else begin
      wr_state_q <= wr_state_d;
      if (w_fire) begin
        wbeat_q <= w.last ? 8'd0 : wbeat_q + 8'd1;  // restart each burst
      end
      if (b_fire) begin
        wr_addr_q <= wr_addr_q + WR_STEP;  // incrementing bursts
      end
    end
  end

  ////////////////////////////////////////
  // read side
  ////////////////////////////////////////
  rd_state_e rd_state_q;
  rd_state_e rd_state_d;
  addr_t     rd_addr_q;  // latched request
  logic      req_fire;
  logic      r_fire;

  assign rd_req_ready = (rd_state_q == RD_IDLE);
  assign req_fire     = rd_req_valid && rd_req_ready;

  assign arvalid = (rd_state_q == RD_ADDR);
  assign ar.addr = rd_addr_q;
  assign ar.len  = LAST_IDX;

  // r beats go out to the user unchanged
  assign rd_data       = r;
  assign rd_data_valid = (rd_state_q == RD_DATA) && rvalid;
  assign rready        = (rd_state_q == RD_DATA) && rd_data_ready;
  assign r_fire        = rvalid && rready;

  always_comb begin
    rd_state_d = rd_state_q;
    case (rd_state_q)
      RD_IDLE: if (req_fire) rd_state_d = RD_ADDR;
      RD_ADDR: if (arready) rd_state_d = RD_DATA;
      RD_DATA: if (r_fire && r.last) rd_state_d = RD_IDLE;
      default: rd_state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge c0_ddr4_ui_clk) begin
    if (req_fire) begin
      rd_addr_q <= rd_req;  // payload
    end
  end

  always_ff @(posedge c0_ddr4_ui_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_state_q <= RD_IDLE;
    end else begin
      rd_state_q <= rd_state_d;  // runs alongside the write fsm
    end
  end

endmodule

/* verilog/burst_fifo.sv */
`timescale 1ns/1ps

module burst_fifo #(
  parameter int unsigned BURST_LEN  = 4,   // beats per axi burst
  parameter int unsigned FIFO_DEPTH = 16   // beats, power of two
) (
  input  logic                c0_ddr4_ui_clk,
  input  logic                rst_n,
  input  ddr_wr_pkg::sample_t sample,
  input  logic                sample_valid,
  output logic                sample_ready,
  output ddr_wr_pkg::beat_t   beat,
  output logic                beat_valid,
  input  logic                beat_ready,
  output logic                burst_avail   // at least one burst stored
);

  import ddr_wr_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

  ////////////////////////////////////////
  // packing
  ////////////////////////////////////////
  beat_t             pack_q;    // lanes collected so far
  logic [LANE_W-1:0] lane_q;    // next lane to fill
  logic              pend_q;    // complete beat stuck behind a full buffer
  beat_t             wr_beat;   // beat going into storage
  logic              s_fire;
  logic              last_lane; // fourth sample accepted now

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////
  beat_t             mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [LVL_W-1:0]  level_q;   // beats held
  logic              full;
  logic              push;
  logic              pop;

  assign full         = (level_q == LVL_W'(FIFO_DEPTH));
  assign sample_ready = !(pend_q && full);  // stall producer, nothing dropped
  assign s_fire       = sample_valid && sample_ready;
  assign last_lane    = s_fire && (lane_q == LANE_W'(WORDS_PER_BEAT - 1));

  // a fresh beat goes straight in with the incoming top sample
  always_comb begin
    wr_beat = pack_q;
    if (!pend_q) begin
      wr_beat[WORDS_PER_BEAT-1] = sample;
    end
  end

  assign push = !full && (pend_q || last_lane);
  assign pop  = beat_valid && beat_ready;

  assign beat        = mem[rd_ptr_q];     // head of buffer
  assign beat_valid  = (level_q != '0);
  assign burst_avail = (level_q >= LVL_W'(BURST_LEN)); // same cycle as level

  always_ff @(posedge c0_ddr4_ui_clk) begin
    if (s_fire) begin
      pack_q[lane_q] <= sample;  // fill current lane
    end
    if (push) begin
      mem[wr_ptr_q] <= wr_beat;
    end
  end

  always_ff @(posedge c0_ddr4_ui_clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_q   <= '0;
      pend_q   <= 1'b0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (s_fire) begin
        lane_q <= lane_q + 1'b1;  // wraps after the top lane
      end
      if (last_lane && full) begin
        pend_q <= 1'b1;           // hold the whole beat in pack_q
      end else if (push) begin
        pend_q <= 1'b0;
      end
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;  // both or neither
      endcase
    end
  end

endmodule

/* verilog/ddr_wr_pkg.sv */
package ddr_wr_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////
  localparam int SAMPLE_W       = 32;                 // one counter sample
  localparam int DATA_W         = 128;                // axi data bus
  localparam int ADDR_W         = 30;                 // byte address, as on the mig port
  localparam int WORDS_PER_BEAT = DATA_W / SAMPLE_W;  // 4 samples per beat
  localparam int LANE_W         = $clog2(WORDS_PER_BEAT); // packing lane index

  ////////////////////////////////////////
  // payload types
  ////////////////////////////////////////
  typedef logic [SAMPLE_W-1:0] sample_t;
  typedef sample_t [WORDS_PER_BEAT-1:0] beat_t;  // sample 0 in the low word
  typedef logic [ADDR_W-1:0] addr_t;

  // aw / ar carry only what varies, the rest is fixed incr full-width
  typedef struct packed {
    addr_t      addr;  // burst start, byte address
    logic [7:0] len;   // beats minus one
  } axi_aw_t;

  typedef struct packed {
    addr_t      addr;  // burst start, byte address
    logic [7:0] len;   // beats minus one
  } axi_ar_t;

  typedef struct packed {
    beat_t data;  // strobe is all ones
    logic  last;  // final beat of burst
  } axi_w_t;

  typedef struct packed {
    beat_t data;
    logic  last;  // final beat of burst
  } axi_r_t;

  ////////////////////////////////////////
  // fsm states
  ////////////////////////////////////////
  typedef enum logic [1:0] {
    WR_IDLE,  // wait for threshold
    WR_ADDR,  // aw pending
    WR_DATA,  // w beats
    WR_RESP   // wait for b
  } wr_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,  // accept user request
    RD_ADDR,  // ar pending
    RD_DATA   // r beats to user
  } rd_state_e;

endpackage

/* verilog/ddr_wr_rd_top.sv */
`timescale 1ns/1ps

module ddr_wr_rd_top #(
  parameter int unsigned       BURST_LEN  = 4,   // write threshold in beats
  parameter int unsigned       FIFO_DEPTH = 16,  // buffer beats
  parameter ddr_wr_pkg::addr_t WR_BASE    = '0
) (
  input  logic                c0_ddr4_ui_clk,
  input  logic                rst_n,
  input  logic                wr_en,
  // axi4 to memory controller
  output ddr_wr_pkg::axi_aw_t aw,
  output logic                awvalid,
  input  logic                awready,
  output ddr_wr_pkg::axi_w_t  w,
  output logic                wvalid,
  input  logic                wready,
  input  logic                bvalid,
  output logic                bready,
  output ddr_wr_pkg::axi_ar_t ar,
  output logic                arvalid,
  input  logic                arready,
  input  ddr_wr_pkg::axi_r_t  r,
  input  logic                rvalid,
  output logic                rready,
  // user read port
  input  ddr_wr_pkg::addr_t   rd_req,
  input  logic                rd_req_valid,
  output logic                rd_req_ready,
  output ddr_wr_pkg::axi_r_t  rd_data,
  output logic                rd_data_valid,
  input  logic                rd_data_ready
);

  import ddr_wr_pkg::*;

  sample_t sample;        // generator to buffer
  logic    sample_valid;
  logic    sample_ready;
  beat_t   beat;          // buffer to master
  logic    beat_valid;
  logic    beat_ready;
  logic    burst_avail;

  ////////////////////////////////////////
  // datapath chain
  ////////////////////////////////////////
  sample_gen u_gen (
    .c0_ddr4_ui_clk (c0_ddr4_ui_clk),
    .rst_n          (rst_n),
    .wr_en          (wr_en),
    .sample         (sample),
    .sample_valid   (sample_valid),
    .sample_ready   (sample_ready)
  );

  burst_fifo #(
    .BURST_LEN  (BURST_LEN),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .c0_ddr4_ui_clk (c0_ddr4_ui_clk),
    .rst_n          (rst_n),
    .sample         (sample),
    .sample_valid   (sample_valid),
    .sample_ready   (sample_ready),
    .beat           (beat),
    .beat_valid     (beat_valid),
    .beat_ready     (beat_ready),
    .burst_avail    (burst_avail)
  );

  axi_burst_master #(
    .BURST_LEN (BURST_LEN),
    .WR_BASE   (WR_BASE)
  ) u_master (
    .c0_ddr4_ui_clk (c0_ddr4_ui_clk),
    .rst_n          (rst_n),
    .beat           (beat),
    .beat_valid     (beat_valid),
    .beat_ready     (beat_ready),
    .burst_avail    (burst_avail),
    .aw             (aw),
    .awvalid        (awvalid),
    .awready        (awready),
    .w              (w),
    .wvalid         (wvalid),
    .wready         (wready),
    .bvalid         (bvalid),
    .bready         (bready),
    .ar             (ar),
    .arvalid        (arvalid),
    .arready        (arready),
    .r              (r),
    .rvalid         (rvalid),
    .rready         (rready),
    .rd_req         (rd_req),
    .rd_req_valid   (rd_req_valid),
    .rd_req_ready   (rd_req_ready),
    .rd_data        (rd_data),
    .rd_data_valid  (rd_data_valid),
    .rd_data_ready  (rd_data_ready)
  );

endmodule

/* verilog/sample_gen.sv */
`timescale 1ns/1ps

module sample_gen (
  input  logic                c0_ddr4_ui_clk,
  input  logic                rst_n,
  input  logic                wr_en,         // write window
  output ddr_wr_pkg::sample_t sample,
  output logic                sample_valid,
  input  logic                sample_ready
);

  import ddr_wr_pkg::*;

  sample_t count_q;  // running sample value, kept across windows
  logic    valid_q;  // registered offer
  logic    s_fire;   // accepted transfer

  assign s_fire       = valid_q && sample_ready;
  assign sample       = count_q;   // held while not accepted
  assign sample_valid = valid_q;

  always_ff @(posedge c0_ddr4_ui_clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
      valid_q <= 1'b0;
    end else begin
      // offer starts the cycle after wr_en, and an offer already
      // on the bus stays until the buffer takes it
      valid_q <= wr_en || (valid_q && !sample_ready);
      if (s_fire) begin
        count_q <= count_q + 1'b1;  // step only on handshake
      end
    end
  end

endmodule
